// ==== include/firCoeffs.svh ====
// Fixed coefficient table of the FIR filter; include it inside a scope that imports firPkg.
// Entry k is applied to the sample that is k strobes old.
`ifndef FIR_COEFFS_SVH
`define FIR_COEFFS_SVH

// A low-pass shape with ripple in the tail.
// Entry 16 holds the most negative coefficient so the full range gets exercised.
localparam coeffT firCoeffTable [MaxTaps] = '{
	8'sd3, -8'sd5, -8'sd9, 8'sd0,
	8'sd14, 8'sd21, 8'sd6, -8'sd27,
	-8'sd48, -8'sd23, 8'sd45, 8'sd110,
	8'sd127, 8'sd84, 8'sd17, -8'sd36,
	8'sh80, -8'sd31, 8'sd8, 8'sd38,
	8'sd41, 8'sd19, -8'sd12, -8'sd30,
	-8'sd25, -8'sd4, 8'sd15, 8'sd22,
	8'sd13, -8'sd2, -8'sd11, -8'sd7
};

`endif

// ==== design/firPkg.sv ====
// Widths and payload types shared by the FIR filter blocks and the testbench.
// Import it with a wildcard in the module header wherever a type is needed.
package firPkg;

	// Input samples are signed two's complement.
	localparam int SampleWidth = 8;

	// Coefficients are signed as well, so a tap product is signed.
	localparam int CoeffWidth = 8;

	// The longest chain the coefficient table can fill.
	localparam int MaxTaps = 32;

	// A full-precision product of one sample and one coefficient.
	localparam int ProductWidth = SampleWidth + CoeffWidth;

	// Guard bits cover the sum of MaxTaps products without overflow.
	localparam int AccWidth = ProductWidth + $clog2(MaxTaps);

	typedef logic signed [SampleWidth-1:0] sampleT;

	typedef logic signed [CoeffWidth-1:0] coeffT;

	typedef logic signed [ProductWidth-1:0] productT;

	// Filter output, with no rounding and no saturation.
	typedef logic signed [AccWidth-1:0] accT;

endpackage

// ==== design/firStageIf.sv ====
// One link of the FIR tap chain, carrying coefficient and sample strobes with their values.
// The driving stage takes the up modport and the receiving stage takes down.
`timescale 1ns/1ns

interface firStageIf import firPkg::*; ();

	// Single-cycle strobe that moves a coefficient one stage along.
	logic coeffShift;

	// Coefficient value that goes with coeffShift.
	coeffT coeff;

	// Single-cycle strobe that shifts the sample delay line.
	logic sampleEn;

	// Sample value that goes with sampleEn.
	sampleT sample;

	// Upstream side, the stage that feeds this link.
	modport up (
		output coeffShift,
		output coeff,
		output sampleEn,
		output sample
	);

	// Downstream side, the stage that consumes this link.
	modport down (
		input coeffShift,
		input coeff,
		input sampleEn,
		input sample
	);

endinterface

// ==== design/firSequencer.sv ====
// Load, settle, run and stop control of the FIR filter.
// It streams the coefficient table into the chain after reset, then forwards samples.
`timescale 1ns/1ns

module firSequencer import firPkg::*; #(
	parameter int Taps = 20
) (
	input logic clock,
	input logic rstN,
	input logic sampleStrobe,
	input logic stopStrobe,
	input sampleT sampleIn,
	output logic filterReady,
	output logic productValid,
	firStageIf.up link0
);

	`include "firCoeffs.svh"

	// Wide enough to count up to MaxTaps - 1.
	localparam int IdxWidth = $clog2(MaxTaps);
	localparam logic [IdxWidth-1:0] LastIdx = IdxWidth'(Taps - 1);

	typedef enum logic [1:0] {
		LoadSt,
		SettleSt,
		RunSt,
		StopSt
	} seqStateT;

	seqStateT state;

	// Counts issued coefficients in load, then waiting cycles in settle.
	logic [IdxWidth-1:0] coeffIdx;

	// The strobe on link0 delayed once, while the tap products are computed.
	logic sampleEnDly;

	// Samples are only taken while running.
	assign filterReady = (state == RunSt);

	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			state <= LoadSt;
			coeffIdx <= '0;
			link0.coeffShift <= 1'b0;
			link0.sampleEn <= 1'b0;
		end else begin
			// Both strobes last one cycle unless a state below raises them.
			link0.coeffShift <= 1'b0;
			link0.sampleEn <= 1'b0;
			case (state)
				LoadSt: begin
					// One coefficient leaves every cycle, highest entry first.
					link0.coeffShift <= 1'b1;
					if (coeffIdx == LastIdx) begin
						state <= SettleSt;
						coeffIdx <= '0;
					end else begin
						coeffIdx <= coeffIdx + 1'b1;
					end
				end
				SettleSt: begin
					// The last shift needs another Taps cycles to reach the far tap.
					if (coeffIdx == LastIdx) begin
						state <= RunSt;
					end else begin
						coeffIdx <= coeffIdx + 1'b1;
					end
				end
				RunSt: begin
					// A sample strobed on the stop edge is still accepted.
					link0.sampleEn <= sampleStrobe;
					if (stopStrobe) begin
						state <= StopSt;
					end
				end
				StopSt: begin
					// Intake is over until the next reset.
					state <= StopSt;
				end
			endcase
		end
	end

	// Link payloads only matter while their strobe is high.
	always_ff @(posedge clock) begin
		if (state == LoadSt) begin
			link0.coeff <= firCoeffTable[Taps - 1 - int'(coeffIdx)];
		end
		if (state == RunSt && sampleStrobe) begin
			link0.sample <= sampleIn;
		end
	end

	// Taps shift one edge after link0 and register products one edge later,
	// so productValid trails the link0 strobe by two cycles.
	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			sampleEnDly <= 1'b0;
			productValid <= 1'b0;
		end else begin
			sampleEnDly <= link0.sampleEn;
			productValid <= sampleEnDly;
		end
	end

endmodule

// ==== design/firTap.sv ====
// One stage of the FIR delay line with its coefficient and registered product.
// Stages are chained through firStageIf links, one link in and one link out.
`timescale 1ns/1ns

module firTap import firPkg::*; (
	input logic clock,
	input logic rstN,
	firStageIf.down prev,
	firStageIf.up next,
	output productT product
);

	// Coefficient held by this tap once loading is done.
	coeffT coeffReg;

	// Sample delay register, zero until the first sample arrives.
	sampleT sampleReg;

	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			coeffReg <= '0;
			sampleReg <= '0;
			next.coeffShift <= 1'b0;
		end else begin
			// The coefficient strobe ripples one stage per cycle.
			next.coeffShift <= prev.coeffShift;
			if (prev.coeffShift) begin
				coeffReg <= prev.coeff;
			end
			if (prev.sampleEn) begin
				sampleReg <= prev.sample;
			end
		end
	end

	// The old coefficient travels on with the strobe, so each wave
	// pushes the whole table one place further down the chain.
	always_ff @(posedge clock) begin
		if (prev.coeffShift) begin
			next.coeff <= coeffReg;
		end
	end

	// Every tap shifts its sample on the same edge.
	// The strobe goes straight through and the value is this tap's register.
	assign next.sampleEn = prev.sampleEn;
	assign next.sample = sampleReg;

	// Both operands are signed, so the product is sign-correct at 16 bits.
	always_ff @(posedge clock) begin
		product <= sampleReg * coeffReg;
	end

endmodule

// ==== design/firAdderTree.sv ====
// Sums all FIR tap products into one registered output with a valid pulse.
// The tree is padded with zero leaves up to the next power of two.
`timescale 1ns/1ns

module firAdderTree import firPkg::*; #(
	parameter int Taps = 20
) (
	input logic clock,
	input logic rstN,
	input logic productValid,
	input productT products [Taps],
	output logic outValid,
	output accT outData
);

	// A single tap gives zero levels, and the root is then the only leaf.
	localparam int Levels = $clog2(Taps);
	localparam int Leaves = 1 << Levels;

	// Heap layout. Node n adds nodes 2n and 2n+1, and node 1 is the root.
	// Leaves sit at indices Leaves through 2*Leaves-1.
	accT treeNodes [1:2*Leaves-1];

	// Products are sign-extended to the accumulator width before any add.
	for (genvar i = 0; i < Leaves; i++) begin : gLeaf
		if (i < Taps) begin : gUsed
			assign treeNodes[Leaves + i] = accT'(products[i]);
		end else begin : gPad
			assign treeNodes[Leaves + i] = '0;
		end
	end

	// Pairwise adders, one level per power of two.
	// AccWidth leaves room for MaxTaps products, so no stage can overflow.
	for (genvar n = 1; n < Leaves; n++) begin : gNode
		assign treeNodes[n] = treeNodes[2 * n] + treeNodes[2 * n + 1];
	end

	// The sum is registered every cycle.
	// It is only meaningful when outValid is high.
	always_ff @(posedge clock) begin
		outData <= treeNodes[1];
	end

	// Valid follows the products by the one register stage of the sum.
	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			outValid <= 1'b0;
		end else begin
			outValid <= productValid;
		end
	end

endmodule

// ==== design/firFilter.sv ====
// Top level of the FIR filter with plain ports for the sample stream and its result.
// Taps sets the chain length, from 1 up to MaxTaps.
`timescale 1ns/1ns

module firFilter import firPkg::*; #(
	parameter int Taps = 20
) (
	input logic clock,
	input logic rstN,
	input logic sampleStrobe,
	input sampleT sampleIn,
	input logic stopStrobe,
	output logic filterReady,
	output logic outValid,
	output accT outData
);

	// One product per tap, summed by the adder tree.
	productT tapProducts [Taps];

	// High in the cycle when every tap product reflects a new sample.
	logic productValid;

	// Link k feeds tap k.
	// The last link leaves the far end of the chain unused.
	firStageIf links [Taps + 1] ();

	firSequencer #(
		.Taps(Taps)
	) sequencer_i (
		.clock(clock),
		.rstN(rstN),
		.sampleStrobe(sampleStrobe),
		.stopStrobe(stopStrobe),
		.sampleIn(sampleIn),
		.filterReady(filterReady),
		.productValid(productValid),
		.link0(links[0].up)
	);

	// The delay line itself, one stage per tap.
	for (genvar k = 0; k < Taps; k++) begin : gTap
		firTap tap_i (
			.clock(clock),
			.rstN(rstN),
			.prev(links[k].down),
			.next(links[k + 1].up),
			.product(tapProducts[k])
		);
	end

	firAdderTree #(
		.Taps(Taps)
	) adder_i (
		.clock(clock),
		.rstN(rstN),
		.productValid(productValid),
		.products(tapProducts),
		.outValid(outValid),
		.outData(outData)
	);

endmodule

// ==== dv/firFilterTb.sv ====
// Self-checking testbench for the FIR filter top level with a 20-tap chain.
// Every output pulse is compared with a software model of the tap sum.
`timescale 1ns/1ns

module firFilterTb import firPkg::*; ();

	// The sequencer has already pulled the table into this compilation unit.
	`undef FIR_COEFFS_SVH
	`include "firCoeffs.svh"

	localparam int Taps = 20;
	localparam int ClockPeriod = 100;
	localparam int DriveDelay = 5;
	localparam int ResetCycles = 5;

	// Stimulus lengths of the individual tests.
	localparam int EarlyStrobes = 12;
	localparam int LoadCycles = 2 * Taps;
	localparam int RandomSamples = 300;
	localparam int MaxGap = 3;
	localparam int BurstSamples = 100;
	localparam int ExtremeSamples = 4 * Taps;
	localparam int StopSamples = 5;
	localparam int LateStrobes = 10;
	localparam int DrainCycles = 10;

	// Worst case of every test added up, with each test's drain time.
	localparam int StimCycles = EarlyStrobes + Taps + 1 + RandomSamples * (MaxGap + 1)
		+ BurstSamples + ExtremeSamples + StopSamples + LateStrobes + 6 * DrainCycles;
	localparam int MarginCycles = 200;
	localparam int TimeoutNs =
		(ResetCycles + LoadCycles + StimCycles + MarginCycles) * ClockPeriod;

	logic clock = 1'b0;
	logic rstN;
	logic sampleStrobe;
	sampleT sampleIn;
	logic stopStrobe;
	logic filterReady;
	logic outValid;
	accT outData;

	// Expected outputs in strobe order, oldest at the front.
	accT expectedQ [$];

	// Accepted samples, newest at index 0; zero before the first accept.
	sampleT history [MaxTaps] = '{default: '0};

	// Running totals kept by the scoreboard, never cleared.
	int acceptedTotal = 0;
	int outputTotal = 0;

	// Totals at the start of the current test.
	int acceptBase = 0;
	int outBase = 0;

	logic [31:0] randState = 32'h8c2887e4;
	string testName = "reset";

	firFilter #(
		.Taps(Taps)
	) dut_i (
		.clock(clock),
		.rstN(rstN),
		.sampleStrobe(sampleStrobe),
		.sampleIn(sampleIn),
		.stopStrobe(stopStrobe),
		.filterReady(filterReady),
		.outValid(outValid),
		.outData(outData)
	);

	always #(ClockPeriod / 2) clock = ~clock;

	// Linear congruential generator with the usual 32-bit constants.
	function automatic logic [31:0] nextRandom();
		randState = randState * 32'd1664525 + 32'd1013904223;
		return randState;
	endfunction

	// Reference model. Shifts in an accepted sample and returns the tap sum
	// over the coefficient table in full precision.
	function automatic accT acceptSample(input sampleT s);
		int sum;
		for (int k = MaxTaps - 1; k > 0; k--) begin
			history[k] = history[k - 1];
		end
		history[0] = s;
		sum = 0;
		for (int k = 0; k < Taps; k++) begin
			sum += int'(firCoeffTable[k]) * int'(history[k]);
		end
		return accT'(sum);
	endfunction

	// Picks the extreme value whose sign pushes the sum towards the chosen side.
	function automatic sampleT extremeSample(input int k, input logic positive);
		if ((firCoeffTable[k] >= 0) == positive) begin
			return sampleT'(127);
		end
		return sampleT'(-128);
	endfunction

	task automatic stopOnFailure(input string reason);
		$display("Failure during %s: %s", testName, reason);
		$display("CHECKS FAILED");
		$fatal(1, "simulation stopped");
	endtask

	task automatic checkAcc(input string name, input accT expected, input accT actual);
		if (actual !== expected) begin
			$display("** Error: %s: expected %0d, actual %0d", name, expected, actual);
			$display("CHECKS FAILED");
			$fatal(1, "output value mismatch");
		end
	endtask

	task automatic checkCount(input string name, input int expected, input int actual);
		if (actual !== expected) begin
			$display("** Error: %s: expected count %0d, actual count %0d", name, expected,
				actual);
			$display("CHECKS FAILED");
			$fatal(1, "count mismatch");
		end
	endtask

	task automatic checkLevel(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			$display("** Error: %s: expected level %b, actual level %b", name, expected, actual);
			$display("CHECKS FAILED");
			$fatal(1, "level mismatch");
		end
	endtask

	// Inputs change a short delay after the rising edge and hold for one cycle.
	task automatic driveSample(input logic strobe, input sampleT value, input logic stop);
		@(posedge clock);
		#(DriveDelay);
		sampleStrobe = strobe;
		sampleIn = value;
		stopStrobe = stop;
	endtask

	task automatic idleCycles(input int n);
		repeat (n) driveSample(1'b0, '0, 1'b0);
	endtask

	task automatic startTest(input string name);
		testName = name;
		acceptBase = acceptedTotal;
		outBase = outputTotal;
	endtask

	// Coefficient loading takes 2*Taps cycles, so the wait is bounded by that.
	task automatic waitReady();
		int waited;
		waited = 0;
		while (filterReady !== 1'b1 && waited <= LoadCycles + DrainCycles) begin
			@(negedge clock);
			waited++;
		end
		if (filterReady !== 1'b1) begin
			stopOnFailure("filterReady did not rise after the coefficient load");
		end
	endtask

	// Lets every pending output arrive within the drain time, watches a few
	// idle cycles for stray pulses and then checks that nothing is left over
	// and how many outputs the test produced.
	task automatic finishTest(input int expectedOutputs);
		int waited;
		waited = 0;
		driveSample(1'b0, '0, 1'b0);
		while (expectedQ.size() != 0 && waited < DrainCycles) begin
			@(negedge clock);
			waited++;
		end
		idleCycles(DrainCycles / 2);
		checkCount(testName, 0, expectedQ.size());
		checkCount(testName, expectedOutputs, outputTotal - outBase);
	endtask

	// Scoreboard, sampled on the falling edge where all signals are stable.
	// A strobe seen with filterReady high is taken at the next rising edge.
	always @(negedge clock) begin : scoreboard
		accT expected;
		if (rstN) begin
			if (outValid) begin
				if (expectedQ.size() == 0) begin
					stopOnFailure("outValid pulsed with no accepted sample pending");
				end else begin
					expected = expectedQ.pop_front();
					checkAcc(testName, expected, outData);
					outputTotal++;
				end
			end
			if (filterReady && sampleStrobe) begin
				expectedQ.push_back(acceptSample(sampleIn));
				acceptedTotal++;
			end
		end
	end

	initial begin : watchdog
		#(TimeoutNs);
		stopOnFailure("watchdog expired before the tests completed");
	end

	initial begin : stimulus
		logic [31:0] r;
		int gap;
		rstN = 1'b0;
		sampleStrobe = 1'b0;
		sampleIn = '0;
		stopStrobe = 1'b0;
		repeat (ResetCycles) @(posedge clock);
		#(DriveDelay);
		rstN = 1'b1;
		@(negedge clock);
		checkLevel("after reset", 1'b0, filterReady);
		checkLevel("after reset", 1'b0, outValid);

		// Strobes during the coefficient load must vanish.
		startTest("dropped before ready");
		for (int i = 0; i < EarlyStrobes; i++) begin
			r = nextRandom();
			driveSample(1'b1, sampleT'(r[23:16]), 1'b0);
		end
		driveSample(1'b0, '0, 1'b0);
		@(negedge clock);
		checkLevel(testName, 1'b0, filterReady);
		waitReady();
		finishTest(0);
		checkCount(testName, 0, acceptedTotal - acceptBase);

		// A unit impulse reads the coefficients back in tap order.
		startTest("impulse response");
		driveSample(1'b1, sampleT'(1), 1'b0);
		for (int i = 0; i < Taps; i++) begin
			driveSample(1'b1, '0, 1'b0);
		end
		finishTest(Taps + 1);

		startTest("random stream");
		for (int i = 0; i < RandomSamples; i++) begin
			r = nextRandom();
			gap = int'(r[5:4]);
			idleCycles(gap);
			driveSample(1'b1, sampleT'(r[23:16]), 1'b0);
		end
		finishTest(RandomSamples);

		// One strobe every cycle keeps three samples in flight.
		startTest("full throughput");
		for (int i = 0; i < BurstSamples; i++) begin
			r = nextRandom();
			driveSample(1'b1, sampleT'(r[23:16]), 1'b0);
		end
		finishTest(BurstSamples);

		// Constant extremes first, then windows that drive the sum to each end.
		startTest("extreme values");
		for (int i = 0; i < Taps; i++) begin
			driveSample(1'b1, sampleT'(-128), 1'b0);
		end
		for (int i = 0; i < Taps; i++) begin
			driveSample(1'b1, sampleT'(127), 1'b0);
		end
		for (int k = Taps - 1; k >= 0; k--) begin
			driveSample(1'b1, extremeSample(k, 1'b1), 1'b0);
		end
		for (int k = Taps - 1; k >= 0; k--) begin
			driveSample(1'b1, extremeSample(k, 1'b0), 1'b0);
		end
		finishTest(ExtremeSamples);

		// The sample strobed together with stop is still taken.
		startTest("stop");
		for (int i = 0; i < StopSamples; i++) begin
			r = nextRandom();
			driveSample(1'b1, sampleT'(r[23:16]), i == StopSamples - 1);
		end
		driveSample(1'b0, '0, 1'b0);
		@(negedge clock);
		checkLevel(testName, 1'b0, filterReady);
		for (int i = 0; i < LateStrobes; i++) begin
			r = nextRandom();
			driveSample(1'b1, sampleT'(r[23:16]), 1'b0);
		end
		finishTest(StopSamples);
		checkCount(testName, StopSamples, acceptedTotal - acceptBase);
		checkLevel(testName, 1'b0, filterReady);

		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule

// ==== build.f ====
+incdir+include
design/firPkg.sv
design/firStageIf.sv
design/firSequencer.sv
design/firTap.sv
design/firAdderTree.sv
design/firFilter.sv
dv/firFilterTb.sv

// ==== run.sh ====
#!/bin/sh
# Builds the FIR filter testbench with Verilator, runs it and looks for the pass line.

if ! cd "$(dirname "$0")"; then
	echo "Cannot enter the project root"
	exit 1
fi

if ! verilator --binary --timing -f build.f --top-module firFilterTb --Mdir obj_dir; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/VfirFilterTb 2>&1)
status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$output" | grep -qx "ALL CHECKS PASSED"; then
	exit 0
fi
echo "Pass line not found in the simulation output"
exit 1
